/* cpuCore.f */
cpuPkg.sv
instrFetch.sv
pcAdder.sv
regFile.sv
alu.sv
controlUnit.sv
cpuCore.sv
tbCpuCore.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbCpuCore -f cpuCore.f -o simv
./obj_dir/simv | tee sim.log

if grep -q "^=== PASS ===$" sim.log; then
	exit 0
fi
exit 1

/* tbCpuCore.sv */
`timescale 1ns/1ps

module tbCpuCore;
	import cpuPkg::*;

	localparam int IMEM_DEPTH = 256; // Instruction memory words
	localparam int ARITH_MAX  = 30; // Instruction limits per test
	localparam int JUMP_MAX   = 20;
	localparam int BRANCH_MAX = 100;
	localparam int HALT_MAX   = 20;
	localparam int UNK_MAX    = 20;
	localparam int WATCHDOG_NS = ((3 * ARITH_MAX + 20) + (3 * JUMP_MAX + 20) +
		(3 * BRANCH_MAX + 20) + (3 * HALT_MAX + 20) + (3 * UNK_MAX + 20)) * 20 * 2;

	logic              clk;
	logic              rst;
	logic              start;
	logic              progWe;
	logic [PC_W-1:0]   progAddr;
	logic [DATA_W-1:0] progData;
	logic [REG_AW-1:0] dbgAddr;
	logic [DATA_W-1:0] dbgData;
	logic [PC_W-1:0]   pc;
	logic              halted;

	logic [31:0] prog [$];   // Program under test
	logic [31:0] expRegs [32]; // Reference model results
	logic [PC_W-1:0] expPc;
	int          expCount;
	int          errorCount = 0;
	int          testCount = 0;
	int          failCount = 0;

	cpuCore #(.IMEM_DEPTH(IMEM_DEPTH)) cpuCore_inst (
		.clk(clk), .rst(rst), .start(start),
		.progWe(progWe), .progAddr(progAddr), .progData(progData),
		.dbgAddr(dbgAddr), .dbgData(dbgData), .pc(pc), .halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	function automatic logic [31:0] encodeR(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {op, rs, rt, rd, 11'd0};
	endfunction

	function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [25:0] tgt);
		return {op, tgt};
	endfunction

	// Instruction-level model of the program in prog
	task automatic predictRun(input int maxInstr);
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [5:0]  op;
		logic        cond;
		logic        stop;
		int          mpc;
		int          npc;
		stop = 1'b0;
		mpc = 0;
		expCount = 0;
		for (int i = 0; i < 32; i++) expRegs[i] = '0;
		while (!stop && expCount < maxInstr) begin
			// Fetch address wraps at the memory depth, empty words act as NOP
			w = (mpc % IMEM_DEPTH < prog.size()) ? prog[mpc % IMEM_DEPTH] : 32'h0;
			op = w[31:26];
			a = expRegs[w[25:21]];
			b = expRegs[w[20:16]];
			npc = mpc + 1;
			cond = 1'b0;
			case (op)
				ADD:  if (w[15:11] != 5'd0) expRegs[w[15:11]] = a + b;
				SUB:  if (w[15:11] != 5'd0) expRegs[w[15:11]] = a - b;
				ADDI: if (w[20:16] != 5'd0) expRegs[w[20:16]] = a + {{16{w[15]}}, w[15:0]};
				J:    npc = int'(w[25:0]);
				JAL: begin
					expRegs[31] = 32'(mpc + 1); // Link
					npc = int'(w[15:0]);
				end
				JR:   npc = int'(a[25:0]);
				BEQ, BNE, BLT, BLET, BGT, BGET: begin
					case (op)
						BEQ:     cond = (a == b);
						BNE:     cond = (a != b);
						BLT:     cond = $signed(a) < $signed(b);
						BLET:    cond = $signed(a) <= $signed(b);
						BGT:     cond = $signed(a) > $signed(b);
						default: cond = $signed(a) >= $signed(b);
					endcase
					npc = cond ? mpc + 1 : int'(w[15:0]); // Holds -> fall through
				end
				HLT: begin
					stop = 1'b1;
					npc = mpc; // PC stays on HLT
				end
				default: ; // NOP and unknown opcodes
			endcase
			mpc = npc;
			expCount++;
		end
		expPc = PC_W'(mpc);
		if (!stop) begin
			$display("Reference model did not reach HLT within %0d instructions", maxInstr);
			errorCount++;
		end
	endtask

	// Reset for 4 cycles, then write prog word by word
	task automatic loadProgram();
		@(posedge clk);
		rst <= 1'b1;
		start <= 1'b0;
		progWe <= 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		if (halted !== 1'b0) begin
			$display("[ERROR] halted = %h after reset, expected 0", halted);
			errorCount++;
		end
		if (pc !== '0) begin
			$display("[ERROR] pc = %h after reset, expected 0", pc);
			errorCount++;
		end
		@(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < prog.size(); i++) begin
			progWe <= 1'b1;
			progAddr <= PC_W'(i);
			progData <= prog[i];
			@(posedge clk);
		end
		progWe <= 1'b0;
	endtask

	task automatic runUntilHalt(input int maxInstr, output int cycles, output logic done);
		int limit;
		limit = 3 * maxInstr + 10;
		cycles = 0;
		done = 1'b0;
		start <= 1'b1; // Entered on a rising edge
		@(posedge clk);
		start <= 1'b0; // This edge samples start
		while (!done && cycles < limit) begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
			done = halted;
		end
	endtask

	task automatic checkReg(input int idx, input logic [31:0] expVal);
		@(posedge clk);
		dbgAddr <= 5'(idx);
		@(negedge clk);
		if (dbgData !== expVal) begin
			$display("[ERROR] dbgData (r%0d) = %h, expected %h", idx, dbgData, expVal);
			errorCount++;
		end
	endtask

	// Load, run and compare everything against the model
	task automatic runProgram(input string name, input int maxInstr);
		int   errBefore;
		int   cycles;
		logic done;
		errBefore = errorCount;
		predictRun(maxInstr);
		loadProgram();
		runUntilHalt(maxInstr, cycles, done);
		if (!done) begin
			$display("halted did not rise within %0d cycles", cycles);
			errorCount++;
		end else begin
			if (cycles != 3 * expCount) begin
				$display("halted rose after %0d cycles, expected %0d", cycles, 3 * expCount);
				errorCount++;
			end
			for (int i = 0; i < 4; i++) begin // PC and halted must hold
				if (pc !== expPc) begin
					$display("[ERROR] pc = %h, expected %h", pc, expPc);
					errorCount++;
				end
				if (halted !== 1'b1) begin
					$display("[ERROR] halted = %h while halted, expected 1", halted);
					errorCount++;
				end
				@(negedge clk);
			end
		end
		for (int i = 0; i < 32; i++) checkReg(i, expRegs[i]);
		testCount++;
		if (errorCount != errBefore) failCount++;
		$display("Test %-10s %s, %0d instructions, %0d errors", name,
			(errorCount == errBefore) ? "passed" : "failed", expCount, errorCount - errBefore);
	endtask

	task automatic arithTest();
		prog.delete();
		for (int i = 1; i <= 6; i++) prog.push_back(encodeI(ADDI, 5'd0, 5'(i), 16'($urandom)));
		prog.push_back(encodeR(ADD, 5'd1, 5'd2, 5'd7));
		prog.push_back(encodeR(SUB, 5'd3, 5'd4, 5'd8));
		prog.push_back(encodeR(ADD, 5'd7, 5'd8, 5'd9));
		prog.push_back(encodeR(SUB, 5'd5, 5'd6, 5'd10));
		prog.push_back(encodeI(ADDI, 5'd1, 5'd11, 16'hFFFF)); // Minus one
		prog.push_back(encodeI(ADDI, 5'd0, 5'd0, 16'($urandom))); // r0 stays zero
		prog.push_back(encodeR(ADD, 5'd1, 5'd2, 5'd0));
		prog.push_back(encodeR(ADD, 5'd0, 5'd3, 5'd12)); // Reads r0 as zero
		prog.push_back(encodeJ(HLT, 26'd0));
		runProgram("arith", ARITH_MAX);
	endtask

	task automatic jumpTest();
		prog.delete();
		prog.push_back(encodeI(ADDI, 5'd0, 5'd1, 16'h0011));
		prog.push_back(encodeJ(J, 26'h0200004)); // High bits kept, fetch wraps to word 4
		prog.push_back(encodeI(ADDI, 5'd0, 5'd2, 16'h0022)); // Skipped
		prog.push_back(encodeI(ADDI, 5'd0, 5'd3, 16'h0033)); // Skipped
		prog.push_back(encodeI(JAL, 5'd3, 5'd7, 16'd8));      // r31 = 0x200005
		prog.push_back(encodeI(ADDI, 5'd0, 5'd4, 16'h0044)); // After return
		prog.push_back(encodeJ(HLT, 26'd0));
		prog.push_back(encodeI(ADDI, 5'd0, 5'd5, 16'h0055)); // Skipped
		prog.push_back(encodeI(ADDI, 5'd0, 5'd6, 16'h0066));
		prog.push_back(encodeI(JR, 5'd31, 5'd0, 16'd0));
		runProgram("jumps", JUMP_MAX);
	endtask

	// Six branches against less, equal and greater pairs with one marker register per case
	task automatic branchTest();
		opcode_e brOps [6] = '{BEQ, BNE, BLT, BLET, BGT, BGET};
		logic [4:0] lhs;
		logic [4:0] rhs;
		int p;
		prog.delete();
		prog.push_back(encodeI(ADDI, 5'd0, 5'd1, 16'hFFF9)); // -7
		prog.push_back(encodeI(ADDI, 5'd0, 5'd2, 16'hFFF9)); // -7
		prog.push_back(encodeI(ADDI, 5'd0, 5'd3, 16'h0004));
		for (int k = 0; k < 18; k++) begin
			p = 3 + 4 * k; // Four words per case
			case (k % 3)
				0: begin // Signed less
					lhs = 5'd1;
					rhs = 5'd3;
				end
				1: begin
					lhs = 5'd1;
					rhs = 5'd2;
				end
				default: begin
					lhs = 5'd3;
					rhs = 5'd1;
				end
			endcase
			prog.push_back(encodeI(brOps[k / 3], lhs, rhs, 16'(p + 3)));
			prog.push_back(encodeI(ADDI, 5'd0, 5'(10 + k), 16'(k * 16 + 1))); // Fall path
			prog.push_back(encodeJ(J, 26'(p + 4)));
			prog.push_back(encodeI(ADDI, 5'd0, 5'(10 + k), 16'(k * 16 + 2))); // Taken path
		end
		prog.push_back(encodeJ(HLT, 26'd0));
		runProgram("branches", BRANCH_MAX);
	endtask

	task automatic haltTest();
		int n;
		n = int'($urandom_range(8, 2));
		prog.delete();
		for (int i = 0; i < n; i++) prog.push_back(encodeJ(NOP, 26'd0));
		prog.push_back(encodeI(ADDI, 5'd0, 5'd9, 16'($urandom)));
		prog.push_back(encodeJ(HLT, 26'd0)); // HLT away from address 0
		runProgram("halt", HALT_MAX);
	endtask

	task automatic unknownTest();
		prog.delete();
		prog.push_back(encodeI(ADDI, 5'd0, 5'd1, 16'h0007));
		prog.push_back(encodeJ(6'd45, 26'($urandom)));
		prog.push_back(encodeJ(6'd10, 26'($urandom)));
		prog.push_back(encodeJ(6'd50, 26'($urandom)));
		prog.push_back(encodeI(ADDI, 5'd1, 5'd2, 16'h0009));
		prog.push_back(encodeJ(HLT, 26'd0));
		runProgram("unknown", UNK_MAX);
	endtask

	initial begin
		rst = 1'b1;
		start = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		dbgAddr = '0;
		void'($urandom(1320));
		arithTest();
		jumpTest();
		branchTest();
		haltTest();
		unknownTest();
		$display("Tests: %0d, failed: %0d, errors: %0d", testCount, failCount, errorCount);
		if (errorCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

/* cpuCore.sv */
`timescale 1ns/1ps

module cpuCore #(
	parameter int IMEM_DEPTH = 256 // Power of two
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      start,
	input  logic                      progWe,
	input  logic [cpuPkg::PC_W-1:0]   progAddr,
	input  logic [cpuPkg::DATA_W-1:0] progData,
	input  logic [cpuPkg::REG_AW-1:0] dbgAddr,
	output logic [cpuPkg::DATA_W-1:0] dbgData,
	output logic [cpuPkg::PC_W-1:0]   pc,
	output logic                      halted
);
	import cpuPkg::*;

	instr_t            instr;
	ctrl_t             ctrl;
	flags_t            flags;
	logic              fetchEn;
	logic              readEn;
	logic [PC_W-1:0]   pcNext;
	logic [PC_W-1:0]   linkAddr;
	logic [DATA_W-1:0] rsData;
	logic [DATA_W-1:0] rtData;
	logic [DATA_W-1:0] immExt;
	logic [DATA_W-1:0] aluB;
	logic [DATA_W-1:0] aluResult;
	logic [DATA_W-1:0] wData;
	logic [REG_AW-1:0] wAddr;

	instrFetch #(.IMEM_DEPTH(IMEM_DEPTH)) instrFetch_inst (
		.clk(clk), .rst(rst),
		.progWe(progWe), .progAddr(progAddr), .progData(progData),
		.fetchEn(fetchEn), .pcLoad(ctrl.pcLoad), .pcNext(pcNext),
		.pc(pc), .instr(instr)
	);

	controlUnit controlUnit_inst (
		.clk(clk), .rst(rst), .start(start),
		.opcode(instr.opcode), .state(),
		.fetchEn(fetchEn), .readEn(readEn),
		.ctrl(ctrl), .halted(halted)
	);

	regFile regFile_inst (
		.clk(clk), .rst(rst), .readEn(readEn),
		.rsAddr(instr.rs), .rtAddr(instr.rt),
		.rsData(rsData), .rtData(rtData),
		.we(ctrl.regWe), .wAddr(wAddr), .wData(wData),
		.dbgAddr(dbgAddr), .dbgData(dbgData)
	);

	assign immExt = {{(DATA_W-16){instr.low.imm[15]}}, instr.low.imm}; // ADDI sign extend
	assign aluB   = ctrl.immSel ? immExt : rtData;

	alu alu_inst (
		.aluOp(ctrl.aluOp), .a(rsData), .b(aluB),
		.result(aluResult), .flags(flags)
	);

	assign linkAddr = pc + PC_W'(1); // Return address for JAL
	assign wData    = (ctrl.wbSel == WB_LINK) ? {{(DATA_W-PC_W){1'b0}}, linkAddr} : aluResult;

	always_comb begin
		case (ctrl.destSel)
			DEST_RD: wAddr = instr.low.r.rd;
			DEST_RT: wAddr = instr.rt;
			default: wAddr = REG_AW'(31); // JAL link
		endcase
	end

	pcAdder pcAdder_inst (
		.pc(pc),
		.saltoJR(rsData[PC_W-1:0]), // Low bits of rs
		.salto(instr[PC_W-1:0]),    // 26-bit jump field
		.desvio(instr.low.imm),
		.addOp(ctrl.addOp),
		.opcode(instr.opcode),
		.flags(flags),
		.pcAtual(pcNext)
	);

endmodule

/* controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
	input  logic            clk,
	input  logic            rst,
	input  logic            start,   // One-cycle pulse in IDLE
	input  cpuPkg::opcode_e opcode,  // From instruction register
	output cpuPkg::state_e  state,
	output logic            fetchEn,
	output logic            readEn,
	output cpuPkg::ctrl_t   ctrl,
	output logic            halted
);
	import cpuPkg::*;

	state_e nextState;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			IDLE:    if (start) nextState = FETCH; // Program already loaded
			FETCH:   nextState = DECODE;
			DECODE:  nextState = EXECUTE;
			EXECUTE: nextState = (opcode == HLT) ? HALTED : FETCH;
			HALTED:  nextState = HALTED; // Only rst leaves
			default: nextState = IDLE;
		endcase
	end

	assign fetchEn = (state == FETCH);
	assign readEn  = (state == DECODE);

	// Halt flag set on the HLT execute edge
	always_ff @(posedge clk) begin
		if (rst) begin
			halted <= 1'b0;
		end else if (state == EXECUTE && opcode == HLT) begin
			halted <= 1'b1;
		end
	end

	// Opcode decode, active in EXECUTE only
	always_comb begin
		ctrl = '0;
		ctrl.aluOp = ALU_PASSB;
		if (state == EXECUTE) begin
			ctrl.pcLoad = 1'b1; // PC updates every execute
			ctrl.addOp  = ADDOP_INC;
			case (opcode)
				ADD, SUB: begin
					ctrl.regWe   = 1'b1;
					ctrl.destSel = DEST_RD;
					ctrl.wbSel   = WB_ALU;
					ctrl.aluOp   = (opcode == ADD) ? ALU_ADD : ALU_SUB;
				end
				ADDI: begin
					ctrl.regWe   = 1'b1;
					ctrl.destSel = DEST_RT;
					ctrl.immSel  = 1'b1; // Sign-extended imm as b
					ctrl.aluOp   = ALU_ADD;
				end
				BEQ, BNE, BLT, BLET, BGT, BGET: begin
					ctrl.addOp = ADDOP_OPC; // Flags pick the path
					ctrl.aluOp = ALU_SUB;
				end
				JAL: begin
					ctrl.addOp   = ADDOP_OPC;
					ctrl.regWe   = 1'b1;
					ctrl.wbSel   = WB_LINK; // pc + 1 into r31
					ctrl.destSel = DEST_R31;
				end
				JR:      ctrl.addOp = ADDOP_OPC;
				J:       ctrl.addOp = ADDOP_JUMP;
				HLT:     ctrl.addOp = ADDOP_HOLD; // PC stays on HLT
				default: ctrl.addOp = ADDOP_INC; // NOP and unknown
			endcase
		end
	end

	// Datapath strobes only right after a fetch and a decode
	assert property (@(posedge clk) disable iff (rst)
		(ctrl.pcLoad || ctrl.regWe) |-> $past(readEn) && $past(fetchEn, 2));

	// Registered halt tracks the HALTED state
	assert property (@(posedge clk) disable iff (rst) halted |-> state == HALTED);
	assert property (@(posedge clk) disable iff (rst) (state == HALTED) |-> halted);

endmodule

/* alu.sv */
`timescale 1ns/1ps

module alu (
	input  cpuPkg::aluOp_e            aluOp,
	input  logic [cpuPkg::DATA_W-1:0] a,      // rs operand
	input  logic [cpuPkg::DATA_W-1:0] b,      // rt or immediate
	output logic [cpuPkg::DATA_W-1:0] result,
	output cpuPkg::flags_t            flags   // Signed a versus b
);
	import cpuPkg::*;

	logic [DATA_W-1:0] sum;
	logic [DATA_W-1:0] diff;
	logic              ovf;

	always_comb begin
		sum  = a + b;
		diff = a - b;
		// Overflow of a - b when signs differ
		ovf  = (a[DATA_W-1] != b[DATA_W-1]) && (diff[DATA_W-1] != a[DATA_W-1]);

		case (aluOp)
			ALU_ADD: result = sum;
			ALU_SUB: result = diff;
			default: result = b; // PASSB
		endcase

		flags.menor = diff[DATA_W-1] ^ ovf; // Less from subtractor sign
		flags.igual = (diff == '0);
		flags.maior = $signed(a) > $signed(b); // Separate comparator

		// Subtractor and comparator must agree
		if (!$isunknown({a, b})) begin
			assert ($onehot(flags))
				else $error("alu: flags not one-hot, a=%0h b=%0h", a, b);
		end
	end

endmodule

/* regFile.sv */
`timescale 1ns/1ps

module regFile (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      readEn,  // Operand capture in DECODE
	input  logic [cpuPkg::REG_AW-1:0] rsAddr,
	input  logic [cpuPkg::REG_AW-1:0] rtAddr,
	output logic [cpuPkg::DATA_W-1:0] rsData,
	output logic [cpuPkg::DATA_W-1:0] rtData,
	input  logic                      we,
	input  logic [cpuPkg::REG_AW-1:0] wAddr,
	input  logic [cpuPkg::DATA_W-1:0] wData,
	input  logic [cpuPkg::REG_AW-1:0] dbgAddr,
	output logic [cpuPkg::DATA_W-1:0] dbgData  // Combinational peek
);
	import cpuPkg::*;

	localparam int NUM_REGS = 2 ** REG_AW;

	logic [DATA_W-1:0] regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0; // All registers start at zero
			end
		end else if (we && (wAddr != '0)) begin
			regs[wAddr] <= wData; // r0 never written
		end
	end

	// Operand registers
	always_ff @(posedge clk) begin
		if (readEn) begin
			rsData <= regs[rsAddr];
			rtData <= regs[rtAddr];
		end
	end

	assign dbgData = regs[dbgAddr];

	// r0 reads zero on every port
	assert property (@(posedge clk) disable iff (rst) (readEn && rsAddr == '0) |=> rsData == '0);
	assert property (@(posedge clk) disable iff (rst) (readEn && rtAddr == '0) |=> rtData == '0);
	assert property (@(posedge clk) disable iff (rst) (dbgAddr == '0) |-> dbgData == '0);

endmodule

/* pcAdder.sv */
`timescale 1ns/1ps

module pcAdder (
	input  logic [cpuPkg::PC_W-1:0] pc,      // Current PC
	input  logic [cpuPkg::PC_W-1:0] saltoJR, // Target from rs
	input  logic [cpuPkg::PC_W-1:0] salto,   // 26-bit jump field
	input  logic [15:0]             desvio,  // Branch and JAL target
	input  logic [1:0]              addOp,
	input  cpuPkg::opcode_e         opcode,
	input  cpuPkg::flags_t          flags,   // Valid only in EXECUTE
	output logic [cpuPkg::PC_W-1:0] pcAtual  // Next PC
);
	import cpuPkg::*;

	logic [PC_W-1:0] pcInc;
	logic [PC_W-1:0] branchTgt;
	logic            condHolds;

	assign pcInc     = pc + PC_W'(1);
	assign branchTgt = {{(PC_W-16){1'b0}}, desvio}; // Zero-extended

	// Branch condition per opcode
	always_comb begin
		case (opcode)
			BEQ:     condHolds = flags.igual;
			BNE:     condHolds = !flags.igual;
			BLT:     condHolds = flags.menor;
			BLET:    condHolds = flags.menor || flags.igual;
			BGT:     condHolds = flags.maior;
			BGET:    condHolds = flags.maior || flags.igual;
			default: condHolds = 1'b1; // Non-branch falls through
		endcase
	end

	always_comb begin
		case (addOp)
			ADDOP_HOLD: pcAtual = pc; // Halted PC stays put
			ADDOP_INC:  pcAtual = pcInc;
			ADDOP_OPC: begin
				case (opcode)
					JAL:     pcAtual = branchTgt; // Call target
					JR:      pcAtual = saltoJR; // Return via register
					// A true condition falls through, a false one takes the target
					default: pcAtual = condHolds ? pcInc : branchTgt;
				endcase
			end
			default:    pcAtual = salto; // Unconditional J
		endcase
	end

endmodule

/* instrFetch.sv */
`timescale 1ns/1ps

module instrFetch #(
	parameter int IMEM_DEPTH = 256
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      progWe,   // Program load strobe
	input  logic [cpuPkg::PC_W-1:0]   progAddr,
	input  logic [cpuPkg::DATA_W-1:0] progData,
	input  logic                      fetchEn,  // Latch instruction at pc
	input  logic                      pcLoad,
	input  logic [cpuPkg::PC_W-1:0]   pcNext,
	output logic [cpuPkg::PC_W-1:0]   pc,
	output cpuPkg::instr_t            instr
);
	import cpuPkg::*;

	localparam int IDX_W = $clog2(IMEM_DEPTH);

	logic [DATA_W-1:0] imem [IMEM_DEPTH]; // Instruction memory
	logic [IDX_W-1:0]  progIdx;
	logic [IDX_W-1:0]  fetchIdx;

	assign progIdx  = progAddr[IDX_W-1:0]; // Address wraps at IMEM_DEPTH
	assign fetchIdx = pc[IDX_W-1:0];

	// Load port, one word per cycle
	always_ff @(posedge clk) begin
		if (progWe) begin
			imem[progIdx] <= progData;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0; // Start at address 0
		end else if (pcLoad) begin
			pc <= pcNext; // Next PC from pcAdder
		end
	end

	// Instruction register, cleared to NOP
	always_ff @(posedge clk) begin
		if (rst) begin
			instr <= '0;
		end else if (fetchEn) begin
			instr <= imem[fetchIdx];
		end
	end

endmodule

/* cpuPkg.sv */
package cpuPkg;

	localparam int PC_W   = 26; // PC and address width
	localparam int DATA_W = 32; // Register and instruction width
	localparam int REG_AW = 5;  // Register address width

	// Next PC selection codes for pcAdder
	localparam logic [1:0] ADDOP_HOLD = 2'b00; // Keep current PC
	localparam logic [1:0] ADDOP_INC  = 2'b01; // PC + 1
	localparam logic [1:0] ADDOP_OPC  = 2'b10; // Branch, JAL or JR by opcode
	localparam logic [1:0] ADDOP_JUMP = 2'b11; // Absolute 26-bit jump

	localparam logic       WB_ALU  = 1'b0; // Write back ALU result
	localparam logic       WB_LINK = 1'b1; // Write back return address

	localparam logic [1:0] DEST_RD  = 2'd0; // R-type destination
	localparam logic [1:0] DEST_RT  = 2'd1; // I-type destination
	localparam logic [1:0] DEST_R31 = 2'd2; // Link register

	typedef enum logic [5:0] {
		NOP  = 6'd0,
		ADD  = 6'd1,
		SUB  = 6'd2,
		ADDI = 6'd3,
		BEQ  = 6'd23, // Branch and jump codes from 23 up
		BNE  = 6'd24,
		BLT  = 6'd25,
		BLET = 6'd26,
		BGT  = 6'd27,
		BGET = 6'd28,
		J    = 6'd29,
		JAL  = 6'd30,
		JR   = 6'd31,
		HLT  = 6'd63
	} opcode_e;

	typedef enum logic [2:0] {IDLE, FETCH, DECODE, EXECUTE, HALTED} state_e;

	typedef enum logic [1:0] {ALU_PASSB, ALU_ADD, ALU_SUB} aluOp_e;

	// R-type view of the low half of the instruction
	typedef struct packed {
		logic [REG_AW-1:0] rd; // Destination for ADD and SUB
		logic [10:0]       funct; // Not decoded
	} rFields_t;

	// rd overlaps the top of the immediate
	typedef union packed {
		logic [15:0] imm; // Immediate or branch target
		rFields_t    r;
	} lowHalf_t;

	typedef struct packed {
		opcode_e           opcode; // Bits 31:26
		logic [REG_AW-1:0] rs;     // Bits 25:21
		logic [REG_AW-1:0] rt;     // Bits 20:16
		lowHalf_t          low;    // Bits 15:0
	} instr_t;

	typedef struct packed {
		logic [1:0] addOp;   // Next PC mode
		logic       pcLoad;  // Update PC this cycle
		logic       regWe;   // Register file write
		logic       wbSel;   // ALU result or link
		logic [1:0] destSel; // rd, rt or r31
		aluOp_e     aluOp;
		logic       immSel;  // Sign-extended immediate as operand b
	} ctrl_t;

	typedef struct packed {
		logic menor; // a < b signed
		logic maior; // a > b signed
		logic igual; // a == b
	} flags_t;

endpackage
